//--- ddr_seq_top.f
ddr_seq_pkg.sv
ddr_seq_regs.sv
seq_cmd_mem.sv
seq_fsm.sv
pause_timer.sv
seq_cmd_decode.sv
var_delay_line.sv
ddr_seq_top.sv
ddr_seq_properties.sv
tb_ddr_seq.sv

//--- Bender.yml
package:
  name: ddr_seq

sources:
  - ddr_seq_pkg.sv
  - ddr_seq_regs.sv
  - seq_cmd_mem.sv
  - seq_fsm.sv
  - pause_timer.sv
  - seq_cmd_decode.sv
  - var_delay_line.sv
  - ddr_seq_top.sv
  - target: test
    files:
      - ddr_seq_properties.sv
      - tb_ddr_seq.sv

//--- tb_ddr_seq.sv
// testbench for the ddr3 command sequencer with wishbone loading, reference model and checker
`timescale 1ns/1ns

module tb_ddr_seq;
    import ddr_seq_pkg::*;

    localparam int        DRIVE_DLY = 5;                   // after the rising edge
    localparam seq_word_t F_DONE    = 32'd1 << DONE_BIT;
    localparam seq_word_t F_WR      = 32'd1 << BUF_WR_BIT;
    localparam seq_word_t F_PAUSE   = 32'd1 << ADD_PAUSE_BIT;

    logic                     mclk;
    logic                     rst;
    wb_req_t                  wb_req;
    wb_rsp_t                  wb_rsp;
    logic                     run_seq;
    logic [CMD_ADDR_BITS-1:0] run_addr;
    chan_tag_t                run_tag;
    logic                     run_busy;
    logic                     run_done;
    ddr_cmd_t                 cmd;
    logic                     cmd_valid;
    logic                     cke;
    logic                     sdrst_n;
    buf_ctl_t                 rbuf;
    buf_ctl_t                 wbuf;
    chan_tag_t                wtag;

    seq_word_t           img [2**CMD_ADDR_BITS];       // what the sequence memory holds
    ddr_cmd_t            exp_cmd [$];
    buf_ctl_t            exp_buf [$];
    logic                exp_done [$];
    int                  exp_gap [$];                  // cycles since last command or 0
    buf_ctl_t            hist [16] = '{default: '0};   // rbuf_o history with [0] one back
    logic [31:0]         seed = 32'h9730;
    logic [31:0]         rd_dat;
    logic [DLY_BITS-1:0] cur_dly = DFLT_WBUF_DELAY;
    chan_tag_t           cur_tag = '0;
    int                  errors = 0;
    int                  checks = 0;
    int                  cmd_cnt = 0;
    int                  done_cnt = 0;
    int                  wr_cnt = 0;                   // delayed write strobes seen
    int                  cyc_n = 0;
    int                  last_cyc = 0;
    int                  done_base = 0;

    ddr_seq_top #(.CMD_ADDR_BITS(CMD_ADDR_BITS), .CMD_PAUSE_BITS(CMD_PAUSE_BITS)) ddr_seq_top_inst (
        .mclk, .rst, .wb_i(wb_req), .wb_o(wb_rsp), .run_seq_i(run_seq), .run_addr_i(run_addr),
        .run_tag_i(run_tag), .run_busy_o(run_busy), .run_done_o(run_done), .cmd_o(cmd),
        .cmd_valid_o(cmd_valid), .cke_o(cke), .sdrst_n_o(sdrst_n), .rbuf_o(rbuf),
        .wbuf_o(wbuf), .wtag_o(wtag)
    );

    initial begin
        mclk = 1'b0;
        forever #50 mclk = ~mclk;  // 100 ns period
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // random word where a nop carries plen in the low address bits
    function automatic seq_word_t make_word(logic nop, logic [CMD_PAUSE_BITS-1:0] plen,
                                            seq_word_t flags);
        seq_word_t w;
        w = lcg_next() & ~(F_DONE | F_WR | F_PAUSE);
        if (nop) begin
            w[RAS_BIT:WE_BIT] = 3'b111;
            w[ADDR_LSB +: CMD_PAUSE_BITS] = plen;
        end else if (w[RAS_BIT:WE_BIT] == 3'b111) begin
            w[WE_BIT] = 1'b0;  // random bits landed on a nop
        end
        return w | flags;
    endfunction

    // walks the image from start to the done word and queues what must come out
    function automatic void build_expected(logic [CMD_ADDR_BITS-1:0] start);
        logic [CMD_ADDR_BITS-1:0] a;
        seq_word_t                w;
        ddr_cmd_t                 c;
        logic                     nop;
        int                       gap;
        int                       plen;
        a = start;
        gap = 0;
        do begin
            w = img[a];
            nop = w[RAS_BIT] && w[CAS_BIT] && w[WE_BIT];
            plen = w[ADDR_LSB +: CMD_PAUSE_BITS];
            c.ras_n = w[RAS_BIT];
            c.cas_n = w[CAS_BIT];
            c.we_n = w[WE_BIT];
            c.ba = w[BA_LSB +: 3];
            c.addr = nop ? '0 : w[ADDR_LSB +: ADDRESS_NUMBER];  // pause length stays off pins
            exp_cmd.push_back(c);
            exp_buf.push_back('{wr: w[BUF_WR_BIT], rd: w[BUF_RD_BIT], page_nxt: gap == 0});
            exp_done.push_back(w[DONE_BIT]);
            exp_gap.push_back(gap);
            if (nop && plen != 0) gap = 1 + plen;
            else if (w[ADD_PAUSE_BIT]) gap = 2;
            else gap = 1;
            a++;
        end while (!w[DONE_BIT]);
    endfunction

    task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic finish_run();
        $display("errors %0d, checks %0d, commands %0d", errors, checks, cmd_cnt);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic timeout_fail(string what);
        errors++;
        $display("timed out waiting for %s at %0t", what, $time);
        finish_run();
    endtask

    task automatic wb_access(logic we, logic [WB_ADR_BITS-1:0] adr, logic [31:0] wdat,
                             output logic [31:0] rdat);
        int t;
        @(posedge mclk);
        #DRIVE_DLY;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        t = 0;
        do begin
            @(negedge mclk);
            t++;
            if (t > 10) timeout_fail("wishbone ack");
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;  // read data valid with ack
        @(posedge mclk);
        #DRIVE_DLY;
        wb_req = '0;
    endtask

    task automatic load_word(logic [CMD_ADDR_BITS-1:0] a, seq_word_t w);
        img[a] = w;
        wb_access(1'b1, {1'b0, a}, w, rd_dat);
    endtask

    task automatic start_run(logic [CMD_ADDR_BITS-1:0] a, chan_tag_t tag);
        int t;
        build_expected(a);
        done_base = done_cnt;
        @(posedge mclk);
        #DRIVE_DLY;
        cur_tag = tag;
        run_seq = 1'b1;
        run_addr = a;
        run_tag = tag;
        @(posedge mclk);
        #DRIVE_DLY;
        run_seq = 1'b0;
        t = 0;
        while (!run_busy) begin
            @(negedge mclk);
            t++;
            if (t > 5) timeout_fail("run_busy_o to rise");
        end
    endtask

    task automatic wait_run_end();
        int t;
        t = 0;
        while (run_busy) begin
            @(negedge mclk);
            t++;
            if (t > 2000) timeout_fail("run_busy_o to fall");
        end
        check_eq("run_done_o pulses", done_cnt - done_base, 1);
        check_eq("commands missing", exp_cmd.size(), 0);
        repeat (20) @(negedge mclk);  // delayed strobes drain
    endtask

    // outputs settled at the falling edge
    always @(negedge mclk) begin : compare
        int gap;
        if (!rst) begin
            cyc_n++;
            check_eq("wbuf_o", wbuf, {hist[cur_dly].wr, 1'b0, hist[cur_dly].page_nxt});
            if (wbuf.wr || wbuf.page_nxt) check_eq("wtag_o", wtag, cur_tag);
            if (wbuf.wr) wr_cnt++;
            for (int i = 15; i > 0; i--) hist[i] = hist[i-1];
            hist[0] = rbuf;
            if (run_done) done_cnt++;
            if (cmd_valid && exp_cmd.size() == 0) begin
                errors++;
                $display("command issued at %0t with no command expected", $time);
            end else if (cmd_valid) begin
                cmd_cnt++;
                gap = exp_gap.pop_front();
                check_eq("cmd_o", cmd, exp_cmd.pop_front());
                check_eq("rbuf_o", rbuf, exp_buf.pop_front());
                check_eq("run_done_o", run_done, exp_done.pop_front());
                if (gap != 0) check_eq("cmd_valid_o spacing", cyc_n - last_cyc, gap);
                last_cyc = cyc_n;
            end else if (rbuf != '0 || run_done) begin
                errors++;
                $display("buffer strobe or run_done_o at %0t without a command", $time);
            end
        end
    end

    initial begin : stimulus
        int                  t;
        int                  base;
        logic [DLY_BITS-1:0] dly;
        rst = 1'b1;
        wb_req = '0;
        run_seq = 1'b0;
        run_addr = '0;
        run_tag = '0;
        repeat (3) @(posedge mclk);
        #DRIVE_DLY;
        rst = 1'b0;
        wb_access(1'b0, ADR_CTRL, 32'd0, rd_dat);
        check_eq("CTRL", rd_dat, 32'd1);
        wb_access(1'b0, ADR_WBUF_DELAY, 32'd0, rd_dat);
        check_eq("WBUF_DELAY", rd_dat, 32'd6);
        check_eq("sdrst_n_o", sdrst_n, 1'b0);
        check_eq("run_busy_o", run_busy, 1'b0);
        check_eq("rbuf_o", rbuf, 32'd0);
        check_eq("wbuf_o", wbuf, 32'd0);
        run_seq = 1'b1;                                // ignored while ddr is in reset
        @(posedge mclk);
        #DRIVE_DLY;
        run_seq = 1'b0;
        repeat (10) @(negedge mclk);
        check_eq("run_busy_o", run_busy, 1'b0);
        check_eq("commands", cmd_cnt, 0);
        wb_access(1'b1, ADR_CTRL, 32'd2, rd_dat);      // release ddr reset with cke on
        check_eq("sdrst_n_o", sdrst_n, 1'b1);
        check_eq("cke_o", cke, 1'b1);
        // back to back commands where words past done never issue
        for (int i = 0; i < 15; i++) begin
            load_word(10'h010 + i, make_word(1'b0, '0, (i == 11) ? F_DONE : '0));
        end
        start_run(10'h010, '{chn: 4'd3, refresh: 1'b0});
        wait_run_end();
        // nop pauses and added pauses
        load_word(10'h100, make_word(1'b0, '0, '0));
        load_word(10'h101, make_word(1'b1, 10'd5, '0));
        load_word(10'h102, make_word(1'b0, '0, F_PAUSE));
        load_word(10'h103, make_word(1'b0, '0, '0));
        load_word(10'h104, make_word(1'b1, 10'd1, '0));
        load_word(10'h105, make_word(1'b0, '0, F_PAUSE));
        load_word(10'h106, make_word(1'b0, '0, F_DONE));
        start_run(10'h100, '{chn: 4'd9, refresh: 1'b1});
        wait_run_end();
        // write strobe delay settings with three writes per run
        for (int i = 0; i < 6; i++) begin
            load_word(10'h200 + i,
                      make_word(1'b0, '0, (i[0] ? F_WR : '0) | ((i == 5) ? F_DONE : '0)));
        end
        for (int k = 0; k < 3; k++) begin
            dly = (k == 0) ? 4'd0 : (k == 1) ? 4'd15 : 4'd6;
            wb_access(1'b1, ADR_WBUF_DELAY, dly, rd_dat);
            cur_dly = dly;
            wb_access(1'b0, ADR_WBUF_DELAY, 32'd0, rd_dat);
            check_eq("WBUF_DELAY", rd_dat, dly);
            base = wr_cnt;
            start_run(10'h200, '{chn: dly, refresh: 1'b0});
            wait_run_end();
            check_eq("wbuf_o.wr pulses", wr_cnt - base, 3);
        end
        // ddr reset in the middle of a long pause aborts the run
        load_word(10'h300, make_word(1'b0, '0, '0));
        load_word(10'h301, make_word(1'b1, 10'd40, '0));
        load_word(10'h302, make_word(1'b0, '0, '0));
        load_word(10'h303, make_word(1'b0, '0, F_DONE));
        base = cmd_cnt;
        start_run(10'h300, '{chn: 4'd5, refresh: 1'b0});
        t = 0;
        while (cmd_cnt - base < 2) begin
            @(negedge mclk);
            t++;
            if (t > 20) timeout_fail("commands before the long pause");
        end
        repeat (5) @(negedge mclk);
        wb_access(1'b1, ADR_CTRL, 32'd3, rd_dat);      // ddr reset on with cke kept
        t = 0;
        while (run_busy) begin
            @(negedge mclk);
            t++;
            if (t > 3) timeout_fail("run_busy_o to clear after ddr reset");
        end
        check_eq("run_done_o pulses", done_cnt - done_base, 0);
        check_eq("sdrst_n_o", sdrst_n, 1'b0);
        exp_cmd.delete();                              // rest of the aborted run
        exp_buf.delete();
        exp_done.delete();
        exp_gap.delete();
        wb_access(1'b1, ADR_CTRL, 32'd2, rd_dat);
        repeat (50) @(negedge mclk);                   // old pause count runs out
        for (int i = 0; i < 4; i++) begin
            load_word(10'h340 + i, make_word(1'b0, '0, (i == 3) ? F_DONE : '0));
        end
        start_run(10'h340, '{chn: 4'd12, refresh: 1'b1});
        wait_run_end();
        finish_run();
    end

endmodule

//--- ddr_seq_properties.sv
// sequencer assertions on wishbone ack, run control and write strobe delay
`timescale 1ns/1ns

module ddr_seq_properties #(
    parameter int DLY_BITS = ddr_seq_pkg::DLY_BITS
) (
    input logic                mclk,
    input logic                rst,
    input logic                ack_i,
    input logic                run_busy_i,
    input logic                run_done_i,
    input logic                cmd_valid_i,
    input logic                rbuf_wr_i,
    input logic                wbuf_wr_i,
    input logic [DLY_BITS-1:0] wbuf_delay_i
);
    logic [2**DLY_BITS-1:0] wr_hist;  // rbuf wr, bit 0 one cycle back

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            wr_hist <= '0;
        end else begin
            wr_hist <= {wr_hist[2**DLY_BITS-2:0], rbuf_wr_i};
        end
    end

    ack_one_cycle: assert property (@(posedge mclk) disable iff (rst) ack_i |=> !ack_i)
        else $error("wishbone ack high for two cycles");

    cmd_in_run: assert property (@(posedge mclk) disable iff (rst) cmd_valid_i |-> run_busy_i)
        else $error("command issued while not busy");

    done_ends_run: assert property (@(posedge mclk) disable iff (rst) run_done_i |=> !run_busy_i)
        else $error("busy still high after done");

    // tap dly gives dly+1 cycles
    wbuf_lines_up: assert property (@(posedge mclk) disable iff (rst)
                                    wbuf_wr_i == wr_hist[wbuf_delay_i])
        else $error("delayed write strobe off its slot");

endmodule

bind ddr_seq_top ddr_seq_properties #(.DLY_BITS(ddr_seq_pkg::DLY_BITS)) u_props (
    .mclk, .rst, .ack_i(wb_o.ack), .run_busy_i(run_busy_o), .run_done_i(run_done_o),
    .cmd_valid_i(cmd_valid_o), .rbuf_wr_i(rbuf_o.wr), .wbuf_wr_i(wbuf_o.wr),
    .wbuf_delay_i(wbuf_delay)
);

//--- ddr_seq_top.sv
// ddr3 command sequencer top with wishbone programming and buffer strobes
`timescale 1ns/1ns

module ddr_seq_top #(
    parameter int CMD_ADDR_BITS  = ddr_seq_pkg::CMD_ADDR_BITS,
    parameter int CMD_PAUSE_BITS = ddr_seq_pkg::CMD_PAUSE_BITS
) (
    input  logic                     mclk,
    input  logic                     rst,
    input  ddr_seq_pkg::wb_req_t     wb_i,
    output ddr_seq_pkg::wb_rsp_t     wb_o,
    input  logic                     run_seq_i,
    input  logic [CMD_ADDR_BITS-1:0] run_addr_i,
    input  ddr_seq_pkg::chan_tag_t   run_tag_i,
    output logic                     run_busy_o,
    output logic                     run_done_o,
    output ddr_seq_pkg::ddr_cmd_t    cmd_o,
    output logic                     cmd_valid_o,
    output logic                     cke_o,
    output logic                     sdrst_n_o,
    output ddr_seq_pkg::buf_ctl_t    rbuf_o,
    output ddr_seq_pkg::buf_ctl_t    wbuf_o,
    output ddr_seq_pkg::chan_tag_t   wtag_o
);
    import ddr_seq_pkg::*;

    logic                     mem_we;
    logic [CMD_ADDR_BITS-1:0] mem_waddr;
    seq_word_t                mem_wdata;
    logic                     ddr_rst;     // also keeps the sequencer idle
    logic [DLY_BITS-1:0]      wbuf_delay;
    logic                     ren;
    logic [CMD_ADDR_BITS-1:0] raddr;
    seq_word_t                word;
    logic                     word_valid;
    logic                     first;
    logic                     hold;
    chan_tag_t                tag;
    buf_ctl_t                 wbuf_in;     // only wr and page_nxt go through the delay

    assign sdrst_n_o = !ddr_rst;
    assign wbuf_in   = '{wr: rbuf_o.wr, rd: 1'b0, page_nxt: rbuf_o.page_nxt};

    ddr_seq_regs u_regs (
        .mclk, .rst, .wb_i, .wb_o,
        .mem_we_o(mem_we), .mem_waddr_o(mem_waddr), .mem_wdata_o(mem_wdata),
        .ddr_rst_o(ddr_rst), .cke_o, .wbuf_delay_o(wbuf_delay)
    );

    seq_cmd_mem #(.CMD_ADDR_BITS(CMD_ADDR_BITS)) u_mem (
        .mclk, .we_i(mem_we), .waddr_i(mem_waddr), .wdata_i(mem_wdata),
        .ren_i(ren), .raddr_i(raddr), .rdata_o(word)
    );

    seq_fsm #(.CMD_ADDR_BITS(CMD_ADDR_BITS)) u_fsm (
        .mclk, .rst, .run_seq_i, .run_addr_i, .run_tag_i,
        .ddr_rst_i(ddr_rst), .hold_i(hold), .word_i(word),
        .ren_o(ren), .raddr_o(raddr), .word_valid_o(word_valid), .first_o(first),
        .tag_o(tag), .run_busy_o, .run_done_o
    );

    pause_timer #(.CMD_PAUSE_BITS(CMD_PAUSE_BITS)) u_pause (
        .mclk, .rst, .word_valid_i(word_valid), .word_i(word), .hold_o(hold)
    );

    seq_cmd_decode u_decode (
        .mclk, .rst, .word_valid_i(word_valid), .first_i(first), .word_i(word),
        .cmd_o, .cmd_valid_o, .buf_o(rbuf_o), .done_o()
    );

    // line up buffer writes with read data coming back from the ddr3
    var_delay_line #(.T(buf_ctl_t), .DLY_BITS(DLY_BITS)) u_wbuf_dly (
        .mclk, .rst, .dly_i(wbuf_delay), .din_i(wbuf_in), .dout_o(wbuf_o)
    );

    var_delay_line #(.T(chan_tag_t), .DLY_BITS(DLY_BITS)) u_wtag_dly (
        .mclk, .rst, .dly_i(wbuf_delay), .din_i(tag), .dout_o(wtag_o)
    );

endmodule

//--- var_delay_line.sv
// programmable delay line, 1 to 2**DLY_BITS cycles, for any packed payload
`timescale 1ns/1ns

module var_delay_line #(
    parameter type T        = logic,
    parameter int  DLY_BITS = ddr_seq_pkg::DLY_BITS
) (
    input  logic                mclk,
    input  logic                rst,
    input  logic [DLY_BITS-1:0] dly_i,
    input  T                    din_i,
    output T                    dout_o
);
    localparam int STAGES = 2**DLY_BITS;

    T sr [STAGES];  // sr[0] is one cycle late

    assign dout_o = sr[dly_i];  // dly_i+1 cycles

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                sr[i] <= '0;  // strobes quiet out of reset
            end
        end else begin
            sr[0] <= din_i;
            for (int i = 1; i < STAGES; i++) begin
                sr[i] <= sr[i-1];
            end
        end
    end

endmodule

//--- seq_cmd_decode.sv
// registered decode of a command word into ddr3 pins and buffer strobes
`timescale 1ns/1ns

module seq_cmd_decode (
    input  logic                   mclk,
    input  logic                   rst,
    input  logic                   word_valid_i,
    input  logic                   first_i,
    input  ddr_seq_pkg::seq_word_t word_i,
    output ddr_seq_pkg::ddr_cmd_t  cmd_o,
    output logic                   cmd_valid_o,
    output ddr_seq_pkg::buf_ctl_t  buf_o,
    output logic                   done_o
);
    import ddr_seq_pkg::*;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cmd_o       <= '{ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1, ba: '0, addr: '0};
            cmd_valid_o <= 1'b0;
            buf_o       <= '0;
            done_o      <= 1'b0;
        end else begin
            cmd_valid_o    <= word_valid_i;
            done_o         <= word_valid_i && word_i[DONE_BIT];
            buf_o.wr       <= word_valid_i && word_i[BUF_WR_BIT];
            buf_o.rd       <= word_valid_i && word_i[BUF_RD_BIT];
            buf_o.page_nxt <= word_valid_i && first_i;  // first word of the run
            if (word_valid_i) begin
                cmd_o.ras_n <= word_i[RAS_BIT];
                cmd_o.cas_n <= word_i[CAS_BIT];
                cmd_o.we_n  <= word_i[WE_BIT];
                cmd_o.ba    <= word_i[BA_LSB +: 3];
                // nop address field is the pause length, keep it off the pins
                cmd_o.addr  <= is_nop(word_i) ? '0 : word_i[ADDR_LSB +: ADDRESS_NUMBER];
            end else begin
                cmd_o.ras_n <= 1'b1;  // nop between commands
                cmd_o.cas_n <= 1'b1;
                cmd_o.we_n  <= 1'b1;
            end
        end
    end

endmodule

//--- pause_timer.sv
// down counter holding off fetch for nop pauses and added pause cycles
`timescale 1ns/1ns

module pause_timer #(
    parameter int CMD_PAUSE_BITS = ddr_seq_pkg::CMD_PAUSE_BITS
) (
    input  logic                   mclk,
    input  logic                   rst,
    input  logic                   word_valid_i,
    input  ddr_seq_pkg::seq_word_t word_i,
    output logic                   hold_o
);
    import ddr_seq_pkg::*;

    logic [CMD_PAUSE_BITS-1:0] cnt;       // remaining idle cycles after this one
    logic [CMD_PAUSE_BITS-1:0] plen;
    logic [CMD_PAUSE_BITS-1:0] len;       // idle cycles this word asks for
    logic                      load;

    assign plen = word_i[ADDR_LSB +: CMD_PAUSE_BITS];
    // nop length wins, a zero length nop can still carry add_pause
    assign len  = (is_nop(word_i) && plen != '0) ? plen
                : CMD_PAUSE_BITS'(word_i[ADD_PAUSE_BIT]);
    assign load = word_valid_i && (len != '0);

    // stops the read in the same cycle the pausing word arrives
    assign hold_o = load || (cnt != '0);

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= len - 1'b1;  // this cycle already counts
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- seq_fsm.sv
// sequencer fsm with fetch address counter, run busy and done
`timescale 1ns/1ns

module seq_fsm #(
    parameter int CMD_ADDR_BITS = ddr_seq_pkg::CMD_ADDR_BITS
) (
    input  logic                     mclk,
    input  logic                     rst,
    input  logic                     run_seq_i,
    input  logic [CMD_ADDR_BITS-1:0] run_addr_i,
    input  ddr_seq_pkg::chan_tag_t   run_tag_i,
    input  logic                     ddr_rst_i,
    input  logic                     hold_i,
    input  ddr_seq_pkg::seq_word_t   word_i,
    output logic                     ren_o,
    output logic [CMD_ADDR_BITS-1:0] raddr_o,
    output logic                     word_valid_o,
    output logic                     first_o,
    output ddr_seq_pkg::chan_tag_t   tag_o,
    output logic                     run_busy_o,
    output logic                     run_done_o
);
    import ddr_seq_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_DRAIN  // done word seen, its command issues now
    } state_t;

    state_t                   state;
    logic [CMD_ADDR_BITS-1:0] addr;
    logic                     rd_pend;    // read issued last cycle
    logic                     start;
    logic                     word_done;
    logic                     hold_ok;    // hold belongs to this run

    assign start     = run_seq_i && (state == S_IDLE) && !ddr_rst_i;
    assign word_done = word_valid_o && word_i[DONE_BIT];
    // a hold left over from an aborted run is ignored until the first word
    assign hold_ok   = !first_o || word_valid_o;

    // words returning outside fetch or during abort are dropped
    assign word_valid_o = rd_pend && (state == S_FETCH) && !ddr_rst_i;
    assign ren_o        = (state == S_FETCH) && !(hold_i && hold_ok) && !word_done;
    assign raddr_o      = addr;
    assign run_busy_o   = state != S_IDLE;
    assign run_done_o   = state == S_DRAIN;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            addr    <= '0;
            rd_pend <= 1'b0;
            first_o <= 1'b0;
            tag_o   <= '0;
        end else begin
            rd_pend <= ren_o;
            if (start) begin
                addr    <= run_addr_i;
                tag_o   <= run_tag_i;  // held for the whole run
                first_o <= 1'b1;
            end else begin
                if (ren_o) addr <= addr + 1'b1;
                if (word_valid_o) first_o <= 1'b0;
            end
            case (state)
                S_IDLE:  if (start) state <= S_FETCH;
                S_FETCH: begin
                    if (ddr_rst_i) state <= S_IDLE;  // abort, no done pulse
                    else if (word_done) state <= S_DRAIN;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- seq_cmd_mem.sv
// command word memory, one write port and a registered read port
`timescale 1ns/1ns

module seq_cmd_mem #(
    parameter int CMD_ADDR_BITS = ddr_seq_pkg::CMD_ADDR_BITS
) (
    input  logic                     mclk,
    input  logic                     we_i,
    input  logic [CMD_ADDR_BITS-1:0] waddr_i,
    input  ddr_seq_pkg::seq_word_t   wdata_i,
    input  logic                     ren_i,
    input  logic [CMD_ADDR_BITS-1:0] raddr_i,
    output ddr_seq_pkg::seq_word_t   rdata_o
);
    import ddr_seq_pkg::*;

    seq_word_t mem [2**CMD_ADDR_BITS];  // inferred block ram

    always_ff @(posedge mclk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        if (ren_i) begin
            rdata_o <= mem[raddr_i];  // holds last word when not reading
        end
    end

endmodule

//--- ddr_seq_regs.sv
// wishbone classic slave with control registers and command memory write port
`timescale 1ns/1ns

module ddr_seq_regs (
    input  logic                                    mclk,
    input  logic                                    rst,
    input  ddr_seq_pkg::wb_req_t                    wb_i,
    output ddr_seq_pkg::wb_rsp_t                    wb_o,
    output logic                                    mem_we_o,
    output logic [ddr_seq_pkg::CMD_ADDR_BITS-1:0]   mem_waddr_o,
    output ddr_seq_pkg::seq_word_t                  mem_wdata_o,
    output logic                                    ddr_rst_o,
    output logic                                    cke_o,
    output logic [ddr_seq_pkg::DLY_BITS-1:0]        wbuf_delay_o
);
    import ddr_seq_pkg::*;

    logic        ack;
    logic [31:0] rdat;   // read data, valid with ack
    logic        req;    // cyc and stb both up
    logic        wr_en;  // write lands on the ack edge
    logic        mem_sel;

    assign req     = wb_i.cyc && wb_i.stb;
    assign wr_en   = req && wb_i.we && ack;
    assign mem_sel = !wb_i.adr[WB_ADR_BITS-1];  // lower half is sequence memory

    assign mem_we_o    = wr_en && mem_sel;
    assign mem_waddr_o = wb_i.adr[CMD_ADDR_BITS-1:0];
    assign mem_wdata_o = wb_i.dat;

    assign wb_o.ack = ack;
    assign wb_o.dat = rdat;

    // single cycle ack, never back to back
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req && !ack;
        end
    end

    always_ff @(posedge mclk) begin
        if (req && !ack) begin
            case (wb_i.adr)
                ADR_CTRL:       rdat <= {30'b0, cke_o, ddr_rst_o};
                ADR_WBUF_DELAY: rdat <= {{(32-DLY_BITS){1'b0}}, wbuf_delay_o};
                default:        rdat <= '0;  // memory region is write only
            endcase
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ddr_rst_o    <= 1'b1;  // ddr held in reset until software releases it
            cke_o        <= 1'b0;
            wbuf_delay_o <= DFLT_WBUF_DELAY;
        end else if (wr_en) begin
            if (wb_i.adr == ADR_CTRL) begin
                ddr_rst_o <= wb_i.dat[0];
                cke_o     <= wb_i.dat[1];
            end
            if (wb_i.adr == ADR_WBUF_DELAY) begin
                wbuf_delay_o <= wb_i.dat[DLY_BITS-1:0];
            end
        end
    end

endmodule

//--- ddr_seq_pkg.sv
// ddr3 command sequencer package with word layout, bus structs and defaults
package ddr_seq_pkg;

    localparam int CMD_ADDR_BITS  = 10;  // 1024 command words
    localparam int CMD_PAUSE_BITS = 10;  // nop pause length field
    localparam int DLY_BITS       = 4;   // write buffer delay setting
    localparam int ADDRESS_NUMBER = 15;  // ddr3 address pins

    localparam logic [DLY_BITS-1:0] DFLT_WBUF_DELAY = 4'd6;  // 7 cycles total

    localparam int WB_ADR_BITS = 11;  // word address, bit 10 selects registers
    localparam logic [WB_ADR_BITS-1:0] ADR_CTRL       = 11'h400;
    localparam logic [WB_ADR_BITS-1:0] ADR_WBUF_DELAY = 11'h401;

    // command word bit positions
    localparam int DONE_BIT      = 31;  // last word of the sequence
    localparam int BUF_WR_BIT    = 30;  // write to buffer (read data)
    localparam int BUF_RD_BIT    = 29;  // read from buffer (write data)
    localparam int ADD_PAUSE_BIT = 28;  // one extra idle cycle after this word
    localparam int RAS_BIT       = 27;
    localparam int CAS_BIT       = 26;
    localparam int WE_BIT        = 25;
    localparam int BA_LSB        = 22;  // 3 bits
    localparam int ADDR_LSB      = 7;   // ADDRESS_NUMBER bits, pause for nop

    typedef logic [31:0] seq_word_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [WB_ADR_BITS-1:0] adr;
        logic [31:0]            dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                      ras_n;
        logic                      cas_n;
        logic                      we_n;
        logic [2:0]                ba;
        logic [ADDRESS_NUMBER-1:0] addr;
    } ddr_cmd_t;

    typedef struct packed {
        logic wr;        // buffer write strobe
        logic rd;        // buffer read strobe
        logic page_nxt;  // advance buffer to next page
    } buf_ctl_t;

    typedef struct packed {
        logic [3:0] chn;
        logic       refresh;  // refresh run, chn not meaningful
    } chan_tag_t;

    // ras/cas/we all high
    function automatic logic is_nop(seq_word_t w);
        return w[RAS_BIT:WE_BIT] == 3'b111;
    endfunction

endpackage
